/* hw/ooo_pkg.sv */
package ooo_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  arch_reg_t;
    typedef logic [5:0]  phys_reg_t;
    typedef logic [7:0]  seq_tag_t;
    typedef logic [1:0]  op_kind_t;

    localparam op_kind_t OP_ADD = 2'd0;
    localparam op_kind_t OP_SUB = 2'd1;
    localparam op_kind_t OP_MUL = 2'd2;
    localparam op_kind_t OP_LI  = 2'd3;

    localparam int NUM_ARCH_REGS  = 32;
    localparam int NUM_PHYS_REGS  = 64;
    localparam int OP_QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W    = $clog2(OP_QUEUE_DEPTH);
    localparam int MUL_STAGES     = 3;

    // op as handed over by the producer, in program order
    typedef struct packed {
        seq_tag_t  tag;
        op_kind_t  kind;
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
        word_t     imm;
    } op_req_t;

    // renamed op with source values already read
    typedef struct packed {
        seq_tag_t  tag;
        op_kind_t  kind;
        arch_reg_t ard;
        phys_reg_t prd;
        phys_reg_t old_prd;
        word_t     opa;
        word_t     opb;
        word_t     imm;
    } exec_req_t;

    typedef struct packed {
        logic      valid;
        seq_tag_t  tag;
        arch_reg_t ard;
        phys_reg_t prd;
        phys_reg_t old_prd;
        word_t     value;
    } wb_t;

    typedef enum logic {
        CTRL_INIT,
        CTRL_RUN
    } ctrl_state_t;

endpackage

/* hw/phys_regfile.sv */
`timescale 1ns/1ps

module phys_regfile (
    input  logic               clk,
    input  logic               rst,
    input  logic               we_alu,
    input  ooo_pkg::wb_t       wd_alu,
    input  logic               we_mul,
    input  ooo_pkg::wb_t       wd_mul,
    input  ooo_pkg::phys_reg_t rs1_idx,
    input  ooo_pkg::phys_reg_t rs2_idx,
    output ooo_pkg::word_t     rs1_val,
    output ooo_pkg::word_t     rs2_val
);
    import ooo_pkg::*;

    word_t data [NUM_PHYS_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_PHYS_REGS; i++) begin
                data[i] <= '0;
            end
        end else begin
            // both ports may land in one cycle, never on the same entry
            if (we_alu && (wd_alu.prd != '0)) begin
                data[wd_alu.prd] <= wd_alu.value;
            end
            if (we_mul && (wd_mul.prd != '0)) begin
                data[wd_mul.prd] <= wd_mul.value;
            end
        end
    end

    // p0 is hardwired zero
    assign rs1_val = (rs1_idx != '0) ? data[rs1_idx] : '0;
    assign rs2_val = (rs2_idx != '0) ? data[rs2_idx] : '0;

endmodule

/* hw/rename_issue_ctrl.sv */
`timescale 1ns/1ps

module rename_issue_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               op_valid,
    input  ooo_pkg::op_req_t   op,
    output logic               credit_ret,
    output ooo_pkg::phys_reg_t rs1_idx,
    output ooo_pkg::phys_reg_t rs2_idx,
    input  ooo_pkg::word_t     rs1_val,
    input  ooo_pkg::word_t     rs2_val,
    output logic               alu_go,
    output ooo_pkg::exec_req_t alu_req,
    output logic               mul_go,
    output ooo_pkg::exec_req_t mul_req,
    input  ooo_pkg::wb_t       alu_wb,
    input  ooo_pkg::wb_t       mul_wb
);
    import ooo_pkg::*;

    ctrl_state_t            state_q;
    phys_reg_t              init_cnt;
    op_req_t                queue [OP_QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] head_q;
    logic [QUEUE_PTR_W-1:0] tail_q;
    logic [QUEUE_PTR_W:0]   count_q;
    phys_reg_t              rat [NUM_ARCH_REGS];

    logic [NUM_PHYS_REGS-1:0] free_q;
    logic [NUM_PHYS_REGS-1:0] ready_q;
    // old mappings whose own writer has not finished yet
    logic [NUM_PHYS_REGS-1:0] pend_q;
    logic [NUM_PHYS_REGS-1:0] wb_done;
    logic [NUM_PHYS_REGS-1:0] wb_release;
    logic [NUM_PHYS_REGS-1:0] wb_defer;
    logic [NUM_PHYS_REGS-1:0] free_avail;
    logic [NUM_PHYS_REGS-1:0] alloc_mask;

    op_req_t   head_op;
    phys_reg_t src1;
    phys_reg_t src2;
    phys_reg_t alloc_idx;
    logic      alloc_ok;
    logic      need_rd;
    logic      issue;
    exec_req_t req;

    // writeback effects on ready and free bits
    always_comb begin
        wb_done  = '0;
        wb_defer = '0;
        if (alu_wb.valid) begin
            wb_done[alu_wb.prd] = 1'b1;
        end
        if (mul_wb.valid) begin
            wb_done[mul_wb.prd] = 1'b1;
        end
        wb_done[0] = 1'b0;
        // a late writer releases a register that was already superseded
        wb_release = wb_done & pend_q;
        if (alu_wb.valid) begin
            if (ready_q[alu_wb.old_prd] || wb_done[alu_wb.old_prd]) begin
                wb_release[alu_wb.old_prd] = 1'b1;
            end else begin
                wb_defer[alu_wb.old_prd] = 1'b1;
            end
        end
        if (mul_wb.valid) begin
            if (ready_q[mul_wb.old_prd] || wb_done[mul_wb.old_prd]) begin
                wb_release[mul_wb.old_prd] = 1'b1;
            end else begin
                wb_defer[mul_wb.old_prd] = 1'b1;
            end
        end
        wb_release[0] = 1'b0;
        wb_defer[0]   = 1'b0;
    end

    // lowest free index, same-cycle frees included
    always_comb begin
        free_avail = free_q | wb_release;
        alloc_ok   = 1'b0;
        alloc_idx  = '0;
        for (int i = NUM_PHYS_REGS - 1; i > 0; i--) begin
            if (free_avail[i]) begin
                alloc_ok  = 1'b1;
                alloc_idx = phys_reg_t'(i);
            end
        end
    end

    always_comb begin
        head_op = queue[head_q];
        src1    = rat[head_op.rs1];
        src2    = rat[head_op.rs2];
        need_rd = (head_op.rd != '0);
        issue   = (state_q == CTRL_RUN) && (count_q != '0) && ready_q[src1] && ready_q[src2]
                  && (!need_rd || alloc_ok);

        alloc_mask = '0;
        if (issue && need_rd) begin
            alloc_mask[alloc_idx] = 1'b1;
        end

        req.tag     = head_op.tag;
        req.kind    = head_op.kind;
        req.ard     = head_op.rd;
        req.prd     = need_rd ? alloc_idx : '0;
        // x0 maps to p0, so no free is requested for it
        req.old_prd = rat[head_op.rd];
        req.opa     = rs1_val;
        req.opb     = rs2_val;
        req.imm     = head_op.imm;
    end

    assign rs1_idx    = src1;
    assign rs2_idx    = src2;
    assign alu_req    = req;
    assign mul_req    = req;
    assign alu_go     = issue && (head_op.kind != OP_MUL);
    assign mul_go     = issue && (head_op.kind == OP_MUL);
    assign credit_ret = issue;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= CTRL_INIT;
            init_cnt <= '0;
            head_q   <= '0;
            tail_q   <= '0;
            count_q  <= '0;
        end else begin
            if (op_valid) begin
                tail_q <= tail_q + 1'b1;
            end
            if (issue) begin
                head_q <= head_q + 1'b1;
            end
            case ({op_valid, issue})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            if (state_q == CTRL_INIT) begin
                init_cnt <= init_cnt + 1'b1;
                if (init_cnt == phys_reg_t'(NUM_PHYS_REGS - 1)) begin
                    state_q <= CTRL_RUN;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid) begin
            queue[tail_q] <= op;
        end
    end

    // one entry per cycle while in init
    always_ff @(posedge clk) begin
        if (state_q == CTRL_INIT) begin
            if (init_cnt < NUM_ARCH_REGS) begin
                rat[arch_reg_t'(init_cnt)] <= '0;
            end
            free_q[init_cnt]  <= (init_cnt != '0);
            ready_q[init_cnt] <= 1'b1;
            pend_q[init_cnt]  <= 1'b0;
        end else begin
            free_q  <= free_avail & ~alloc_mask;
            ready_q <= (ready_q | wb_done) & ~alloc_mask;
            pend_q  <= (pend_q & ~wb_done) | wb_defer;
            if (issue && need_rd) begin
                rat[head_op.rd] <= alloc_idx;
            end
        end
    end

endmodule

/* hw/int_alu.sv */
`timescale 1ns/1ps

module int_alu (
    input  logic               clk,
    input  logic               rst,
    input  logic               go,
    input  ooo_pkg::exec_req_t req,
    output ooo_pkg::wb_t       wb
);
    import ooo_pkg::*;

    word_t result;

    always_comb begin
        case (req.kind)
            OP_SUB:  result = req.opa - req.opb;
            OP_LI:   result = req.imm;
            default: result = req.opa + req.opb;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= go;
        end
        if (go) begin
            wb.tag     <= req.tag;
            wb.ard     <= req.ard;
            wb.prd     <= req.prd;
            wb.old_prd <= req.old_prd;
            // x0 results always report zero
            wb.value   <= (req.ard != '0) ? result : '0;
        end
    end

endmodule

/* hw/mul_pipe.sv */
`timescale 1ns/1ps

module mul_pipe (
    input  logic               clk,
    input  logic               rst,
    input  logic               go,
    input  ooo_pkg::exec_req_t req,
    output ooo_pkg::wb_t       wb
);
    import ooo_pkg::*;

    wb_t   stage [MUL_STAGES];
    word_t product;

    // low half of the product only
    assign product = req.opa * req.opb;

    always_ff @(posedge clk) begin
        stage[0].valid   <= go;
        stage[0].tag     <= req.tag;
        stage[0].ard     <= req.ard;
        stage[0].prd     <= req.prd;
        stage[0].old_prd <= req.old_prd;
        stage[0].value   <= (req.ard != '0) ? product : '0;
        for (int i = 1; i < MUL_STAGES; i++) begin
            stage[i] <= stage[i-1];
        end
        if (rst) begin
            for (int i = 0; i < MUL_STAGES; i++) begin
                stage[i].valid <= 1'b0;
            end
        end
    end

    // result leaves MUL_STAGES cycles after go
    assign wb = stage[MUL_STAGES-1];

endmodule

/* hw/exec_core_top.sv */
`timescale 1ns/1ps

module exec_core_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             op_valid,
    input  ooo_pkg::op_req_t op,
    output logic             credit_ret,
    output ooo_pkg::wb_t     alu_wb,
    output ooo_pkg::wb_t     mul_wb
);
    import ooo_pkg::*;

    phys_reg_t rs1_idx;
    phys_reg_t rs2_idx;
    word_t     rs1_val;
    word_t     rs2_val;
    logic      alu_go;
    logic      mul_go;
    exec_req_t alu_req;
    exec_req_t mul_req;

    rename_issue_ctrl i_rename_issue_ctrl (
        .clk        (clk),
        .rst        (rst),
        .op_valid   (op_valid),
        .op         (op),
        .credit_ret (credit_ret),
        .rs1_idx    (rs1_idx),
        .rs2_idx    (rs2_idx),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .alu_go     (alu_go),
        .alu_req    (alu_req),
        .mul_go     (mul_go),
        .mul_req    (mul_req),
        .alu_wb     (alu_wb),
        .mul_wb     (mul_wb)
    );

    phys_regfile i_phys_regfile (
        .clk     (clk),
        .rst     (rst),
        .we_alu  (alu_wb.valid),
        .wd_alu  (alu_wb),
        .we_mul  (mul_wb.valid),
        .wd_mul  (mul_wb),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val)
    );

    // results go to the regfile and out of the core alike
    int_alu i_int_alu (
        .clk (clk),
        .rst (rst),
        .go  (alu_go),
        .req (alu_req),
        .wb  (alu_wb)
    );

    mul_pipe i_mul_pipe (
        .clk (clk),
        .rst (rst),
        .go  (mul_go),
        .req (mul_req),
        .wb  (mul_wb)
    );

endmodule

/* dv/exec_core_sva.sv */
`timescale 1ns/1ps

module exec_core_sva (
    input logic                             clk,
    input logic                             rst,
    input logic                             op_valid,
    input logic                             issue,
    input logic [ooo_pkg::QUEUE_PTR_W:0]    count,
    input logic                             alu_go,
    input logic                             mul_go,
    input ooo_pkg::wb_t                     alu_wb,
    input ooo_pkg::wb_t                     mul_wb
);
    import ooo_pkg::*;

    // a full queue must not take a new op unless the head leaves
    queue_no_overflow: assert property (@(posedge clk) disable iff (rst)
        !(op_valid && !issue && (count == (QUEUE_PTR_W + 1)'(OP_QUEUE_DEPTH))))
        else $error("op queue overflow");

    one_go_per_cycle: assert property (@(posedge clk) disable iff (rst)
        !(alu_go && mul_go))
        else $error("alu_go and mul_go high together");

    wb_distinct_prd: assert property (@(posedge clk) disable iff (rst)
        (alu_wb.valid && mul_wb.valid && (alu_wb.prd != '0)) |-> (alu_wb.prd != mul_wb.prd))
        else $error("two writebacks to one physical register");

endmodule

bind rename_issue_ctrl exec_core_sva i_exec_core_sva (
    .clk        (clk),
    .rst        (rst),
    .op_valid   (op_valid),
    .issue      (issue),
    .count      (count_q),
    .alu_go     (alu_go),
    .mul_go     (mul_go),
    .alu_wb     (alu_wb),
    .mul_wb     (mul_wb)
);

/* dv/exec_core_tb.sv */
`timescale 1ns/1ps

module exec_core_tb;
    import ooo_pkg::*;

    localparam int NUM_LI          = NUM_ARCH_REGS;
    localparam int NUM_CHAIN       = 24;
    localparam int NUM_MIXED       = 32;
    localparam int NUM_RANDOM      = 300;
    localparam int NUM_OPS         = NUM_LI + NUM_CHAIN + NUM_MIXED + NUM_RANDOM;
    localparam int RESET_CYCLES    = 10;
    localparam int WATCHDOG_CYCLES = 40 * NUM_OPS + NUM_PHYS_REGS + RESET_CYCLES;

    logic    clk;
    logic    rst;
    logic    op_valid;
    op_req_t op;
    logic    credit_ret;
    wb_t     alu_wb;
    wb_t     mul_wb;

    op_req_t ops [NUM_OPS];
    bit      done [NUM_OPS];
    int      num_built;
    int      sent;
    int      credits;
    int      done_count;
    int      ret_count;

    // physical registers reported by each finished op
    phys_reg_t done_prd     [NUM_OPS];
    phys_reg_t done_old_prd [NUM_OPS];

    exec_core_top i_exec_core_top (
        .clk        (clk),
        .rst        (rst),
        .op_valid   (op_valid),
        .op         (op),
        .credit_ret (credit_ret),
        .alu_wb     (alu_wb),
        .mul_wb     (mul_wb)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_wb_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_arch_reg(input string name, input arch_reg_t got,
                                  input arch_reg_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_phys_reg(input string name, input phys_reg_t got,
                                  input phys_reg_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_tag_unit(input string name, input seq_tag_t got, input seq_tag_t exp,
                                  input logic on_mul, input op_kind_t kind);
        if (on_mul != (kind == OP_MUL)) begin
            stop_on_error($sformatf("op with tag %h finished on the wrong unit port", got));
        end
        if (got !== exp) begin
            stop_on_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
        end
    endtask

    // in-order replay of ops 0..idx on the architectural registers
    function automatic word_t ref_result(input int idx, output arch_reg_t ard);
        word_t regs [NUM_ARCH_REGS];
        word_t a;
        word_t b;
        word_t v;
        for (int r = 0; r < NUM_ARCH_REGS; r++) begin
            regs[r] = '0;
        end
        v = '0;
        for (int i = 0; i <= idx; i++) begin
            a = regs[ops[i].rs1];
            b = regs[ops[i].rs2];
            case (ops[i].kind)
                OP_ADD:  v = a + b;
                OP_SUB:  v = a - b;
                OP_MUL:  v = a * b;
                default: v = ops[i].imm;
            endcase
            if (ops[i].rd == '0) begin
                v = '0;
            end
            regs[ops[i].rd] = v;
        end
        ard = ops[idx].rd;
        return v;
    endfunction

    // tags wrap, so take the oldest unfinished op with this tag
    function automatic int find_op(input seq_tag_t tag);
        for (int i = 0; i < sent; i++) begin
            if (!done[i] && (ops[i].tag == tag)) begin
                return i;
            end
        end
        return -1;
    endfunction

    // in-order issue and fixed latency keep each port in program order
    function automatic int oldest_on_port(input logic on_mul);
        for (int i = 0; i < sent; i++) begin
            if (!done[i] && ((ops[i].kind == OP_MUL) == on_mul)) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic add_op(input op_kind_t kind, input arch_reg_t rd, input arch_reg_t rs1,
                          input arch_reg_t rs2, input word_t imm);
        op_req_t o;
        o.tag  = seq_tag_t'(num_built);
        o.kind = kind;
        o.rd   = rd;
        o.rs1  = rs1;
        o.rs2  = rs2;
        o.imm  = imm;
        ops[num_built] = o;
        done[num_built] = 1'b0;
        num_built++;
    endtask

    // old_prd chains to the prd of the previous writer of the same register
    task automatic check_rename(input int idx, input string port_name);
        int earlier;
        int later;
        earlier = -1;
        later   = -1;
        for (int i = 0; i < idx; i++) begin
            if (ops[i].rd == ops[idx].rd) begin
                earlier = i;
            end
        end
        for (int i = sent - 1; i > idx; i--) begin
            if (ops[i].rd == ops[idx].rd) begin
                later = i;
            end
        end
        if (ops[idx].rd == '0) begin
            check_phys_reg({port_name, ".prd"}, done_prd[idx], '0);
            check_phys_reg({port_name, ".old_prd"}, done_old_prd[idx], '0);
        end else begin
            if (done_prd[idx] == '0) begin
                stop_on_error($sformatf("op with tag %h wrote x%0d without a physical register",
                                        ops[idx].tag, ops[idx].rd));
            end
            if (earlier < 0) begin
                check_phys_reg({port_name, ".old_prd"}, done_old_prd[idx], '0);
            end else if (done[earlier]) begin
                check_phys_reg({port_name, ".old_prd"}, done_old_prd[idx], done_prd[earlier]);
            end
            if ((later >= 0) && done[later]) begin
                check_phys_reg($sformatf("old_prd of tag %h", ops[later].tag),
                               done_old_prd[later], done_prd[idx]);
            end
        end
    endtask

    task automatic check_result(input wb_t wb, input logic on_mul);
        int        idx;
        int        exp_idx;
        string     port_name;
        arch_reg_t exp_ard;
        word_t     exp_value;
        port_name = on_mul ? "mul_wb" : "alu_wb";
        idx       = find_op(wb.tag);
        if (idx < 0) begin
            stop_on_error($sformatf("result tag %h matches no outstanding op", wb.tag));
        end else begin
            exp_idx = oldest_on_port(on_mul);
            // no op of this kind outstanding, the port check below fails
            if (exp_idx < 0) begin
                exp_idx = idx;
            end
            check_tag_unit({port_name, ".tag"}, wb.tag, ops[exp_idx].tag,
                           on_mul, ops[idx].kind);
            done[idx] = 1'b1;
            exp_value = ref_result(idx, exp_ard);
            check_arch_reg({port_name, ".ard"}, wb.ard, exp_ard);
            check_wb_value({port_name, ".value"}, wb.value, exp_value);
            done_prd[idx]     = wb.prd;
            done_old_prd[idx] = wb.old_prd;
            check_rename(idx, port_name);
            done_count++;
        end
    endtask

    // result monitor and credit pulse counter
    always @(posedge clk) begin
        if (!rst) begin
            if (credit_ret) begin
                ret_count++;
            end
            if (alu_wb.valid) begin
                check_result(alu_wb, 1'b0);
            end
            if (mul_wb.valid) begin
                check_result(mul_wb, 1'b1);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_on_error($sformatf("watchdog expired with %0d of %0d ops complete",
                                done_count, NUM_OPS));
    end

    initial begin
        void'($urandom(32'h042dc4fb));
        rst        = 1'b1;
        op_valid   = 1'b0;
        op         = '0;
        num_built  = 0;
        done_count = 0;
        ret_count  = 0;

        // LI to every register, x0 too
        for (int r = 0; r < NUM_LI; r++) begin
            add_op(OP_LI, arch_reg_t'(r), '0, '0, $urandom());
        end
        // each op reads the two results just before it
        for (int i = 0; i < NUM_CHAIN; i++) begin
            add_op((i % 2 == 1) ? OP_SUB : OP_ADD, arch_reg_t'(1 + i % 6),
                   arch_reg_t'(1 + (i + 5) % 6), arch_reg_t'(1 + (i + 4) % 6), '0);
        end
        // every third op is a MUL
        for (int i = 0; i < NUM_MIXED; i++) begin
            add_op((i % 3 == 0) ? OP_MUL : op_kind_t'($urandom_range(0, 1)),
                   arch_reg_t'(8 + i % 8), arch_reg_t'(8 + (i + 7) % 8),
                   arch_reg_t'($urandom()), '0);
        end
        for (int i = 0; i < NUM_RANDOM; i++) begin
            add_op(op_kind_t'($urandom()), arch_reg_t'($urandom()), arch_reg_t'($urandom()),
                   arch_reg_t'($urandom()), $urandom());
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        if (credit_ret || alu_wb.valid || mul_wb.valid ||
            i_exec_core_top.alu_go || i_exec_core_top.mul_go) begin
            stop_on_error("control or result outputs active right after reset");
        end

        // full rate, limited only by credits
        credits = OP_QUEUE_DEPTH;
        sent    = 0;
        while (sent < NUM_OPS) begin
            @(posedge clk);
            if (credit_ret) begin
                credits++;
            end
            if (credits > 0) begin
                op_valid <= 1'b1;
                op       <= ops[sent];
                sent++;
                credits--;
            end else begin
                op_valid <= 1'b0;
            end
        end
        @(posedge clk);
        op_valid <= 1'b0;

        wait (done_count == NUM_OPS);
        repeat (4) @(posedge clk);
        if (ret_count != sent) begin
            stop_on_error($sformatf("%0d credit pulses returned for %0d ops sent",
                                    ret_count, sent));
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

/* files.f */
hw/ooo_pkg.sv
hw/phys_regfile.sv
hw/rename_issue_ctrl.sv
hw/int_alu.sv
hw/mul_pipe.sv
hw/exec_core_top.sv
dv/exec_core_sva.sv
dv/exec_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the exec core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module exec_core_tb -f files.f -o exec_core_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/exec_core_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Finished with errors" sim.log; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi
exit 0
